// File: filelist.f
+incdir+include
logic/tri_setup_pkg.sv
logic/pipe_stage.sv
logic/area_unit.sv
logic/numerator_unit.sv
logic/plane_divider.sv
logic/tri_setup.sv
tb/tri_setup_tb.sv

// File: Makefile
SIM_BIN = obj_dir/sim_tri_setup

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f filelist.f --top-module tri_setup

sim:
	verilator --binary --timing --assert -j 0 -f filelist.f \
		--top-module tri_setup_tb -o sim_tri_setup --Mdir obj_dir
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf obj_dir

// File: tb/tri_setup_tb.sv
`timescale 1ns/1ps
`include "tri_setup_params.svh"

module tri_setup_tb;
   import tri_setup_pkg::*;

   localparam int SEND_TIMEOUT   = 1000;
   localparam int RESULT_TIMEOUT = 200;
   localparam int NUM_RANDOM     = 200;

   logic      clk;
   logic      rst;
   logic      in_valid;
   logic      in_ready;
   triangle_t in_tri;
   logic      out_valid;
   logic      out_ready;
   plane_t    out_plane;

   tri_setup uut (
      .clk      (clk),
      .rst      (rst),
      .in_valid (in_valid),
      .in_ready (in_ready),
      .in_tri   (in_tri),
      .out_valid(out_valid),
      .out_ready(out_ready),
      .out_plane(out_plane)
   );

   always #5 clk = ~clk;

   task automatic abort_run(input string what);
      $display("%s", what);
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic compare_coef(input string name, input coef_t expected, input coef_t actual);
      if (expected !== actual) begin
         abort_run($sformatf("Error: %s expected 0x%016h actual 0x%016h",
                             name, expected, actual));
      end
   endtask

   task automatic compare_flag(input string name, input logic expected, input logic actual);
      if (expected !== actual) begin
         abort_run($sformatf("Error: %s expected 0x%0h actual 0x%0h", name, expected, actual));
      end
   endtask

   task automatic check_plane(input plane_t expected, input plane_t actual);
      compare_coef("cx", expected.cx, actual.cx);
      compare_coef("cy", expected.cy, actual.cy);
      compare_coef("cs", expected.cs, actual.cs);
      compare_flag("degenerate", expected.degenerate, actual.degenerate);
   endtask

   // Sign-magnitude divide of n * 2^64 by d, keeping quotient bits 111..48.
   function automatic coef_t scaled_quotient(input coef_t n, input coef_t d);
      logic [`COEF_W-1:0]   mag_n;
      logic [`COEF_W-1:0]   mag_d;
      logic [2*`COEF_W-1:0] wide_q;
      coef_t                r;
      mag_n  = (n < 0) ? -n : n;
      mag_d  = (d < 0) ? -d : d;
      wide_q = {mag_n, {`COEF_W{1'b0}}} / {{`COEF_W{1'b0}}, mag_d};
      r      = wide_q[2*`COEF_W-1-`FRAC_BITS:`COEF_W-`FRAC_BITS];
      if ((n < 0) != (d < 0)) begin
         r = -r;
      end
      return r;
   endfunction

   function automatic plane_t model_plane(input triangle_t t);
      longint x0, y0, x1, y1, x2, y2, s0, s1, s2;
      coef_t  det, ncx, ncy, ncs;
      plane_t p;
      x0  = longint'(t.x0);
      y0  = longint'(t.y0);
      x1  = longint'(t.x1);
      y1  = longint'(t.y1);
      x2  = longint'(t.x2);
      y2  = longint'(t.y2);
      s0  = longint'(t.s0);
      s1  = longint'(t.s1);
      s2  = longint'(t.s2);
      det = x0 * (y1 - y2) + x1 * (y2 - y0) + x2 * (y0 - y1);
      ncx = s0 * (y1 - y2) + s1 * (y2 - y0) + s2 * (y0 - y1);
      ncy = s0 * (x2 - x1) + s1 * (x0 - x2) + s2 * (x1 - x0);
      ncs = s0 * (x1 * y2 - x2 * y1) + s1 * (x2 * y0 - x0 * y2) + s2 * (x0 * y1 - x1 * y0);
      p = '0;
      if (det == 0) begin
         p.degenerate = 1'b1;
      end else begin
         p.cx = scaled_quotient(ncx, det);
         p.cy = scaled_quotient(ncy, det);
         p.cs = scaled_quotient(ncs, det);
      end
      return p;
   endfunction

   function automatic triangle_t make_tri(input int x0, y0, x1, y1, x2, y2, s0, s1, s2);
      triangle_t t;
      t.x0 = `COORD_W'(x0);
      t.y0 = `COORD_W'(y0);
      t.x1 = `COORD_W'(x1);
      t.y1 = `COORD_W'(y1);
      t.x2 = `COORD_W'(x2);
      t.y2 = `COORD_W'(y2);
      t.s0 = `ATTR_W'(s0);
      t.s1 = `ATTR_W'(s1);
      t.s2 = `ATTR_W'(s2);
      return t;
   endfunction

   function automatic triangle_t random_tri();
      return make_tri($urandom_range(4095), $urandom_range(4095), $urandom_range(4095),
                      $urandom_range(4095), $urandom_range(4095), $urandom_range(4095),
                      $urandom_range(4095), $urandom_range(4095), $urandom_range(4095));
   endfunction

   // Called on a falling edge. Returns on the falling edge after the transfer.
   task automatic send_tri(input triangle_t t);
      int cnt;
      cnt      = 0;
      in_tri   = t;
      in_valid = 1'b1;
      while (!in_ready) begin
         @(negedge clk);
         cnt++;
         if (cnt > SEND_TIMEOUT) begin
            abort_run("Timeout: the DUT never accepted a triangle.");
         end
      end
      @(negedge clk);
      in_valid = 1'b0;
   endtask

   task automatic receive_plane(input plane_t expected, input int stall_pct);
      int   cnt;
      logic got;
      cnt = 0;
      got = 1'b0;
      while (!got) begin
         out_ready = (int'($urandom_range(99)) >= stall_pct);
         if (out_valid && out_ready) begin
            check_plane(expected, out_plane);
            got = 1'b1;
         end
         @(negedge clk);
         cnt++;
         if (!got && cnt > RESULT_TIMEOUT) begin
            abort_run("Timeout: no plane result arrived from the DUT.");
         end
      end
   endtask

   task automatic test_linear_ccw();
      plane_t expected;
      expected            = '0;
      expected.cx         = 64'sd2 <<< `FRAC_BITS;
      expected.cy         = 64'sd3 <<< `FRAC_BITS;
      expected.cs         = 64'sd5 <<< `FRAC_BITS;
      send_tri(make_tri(10, 10, 100, 20, 30, 90, 55, 265, 335));
      receive_plane(expected, 0);
   endtask

   task automatic test_clockwise();
      triangle_t t;
      // s = 4000 - 10x + y with the vertices in clockwise order.
      t = make_tri(10, 10, 30, 90, 100, 20, 3910, 3790, 3020);
      send_tri(t);
      receive_plane(model_plane(t), 0);
   endtask

   task automatic test_collinear();
      plane_t expected;
      expected            = '0;
      expected.degenerate = 1'b1;
      send_tri(make_tri(0, 0, 50, 50, 200, 200, 7, 300, 4000));
      receive_plane(expected, 0);
   endtask

   task automatic test_backpressure();
      triangle_t tris [3];
      plane_t    held;
      int        cnt;
      for (int i = 0; i < 3; i++) begin
         tris[i] = random_tri();
      end
      out_ready = 1'b0;
      fork
         begin
            for (int i = 0; i < 3; i++) begin
               send_tri(tris[i]);
            end
         end
         begin
            cnt = 0;
            while (!out_valid) begin
               @(negedge clk);
               cnt++;
               if (cnt > RESULT_TIMEOUT) begin
                  abort_run("Timeout: the first stalled result never became valid.");
               end
            end
            held = out_plane;
            cnt  = 0;
            while (in_ready) begin
               @(negedge clk);
               check_plane(held, out_plane);
               cnt++;
               if (cnt > RESULT_TIMEOUT) begin
                  abort_run("Timeout: in_ready never dropped under back-pressure.");
               end
            end
            repeat (10) begin
               @(negedge clk);
               compare_flag("out_valid", 1'b1, out_valid);
               check_plane(held, out_plane);
            end
            for (int i = 0; i < 3; i++) begin
               receive_plane(model_plane(tris[i]), 0);
            end
         end
      join
   endtask

   task automatic test_random();
      triangle_t tris [NUM_RANDOM];
      for (int i = 0; i < NUM_RANDOM; i++) begin
         tris[i] = random_tri();
      end
      fork
         begin
            for (int i = 0; i < NUM_RANDOM; i++) begin
               send_tri(tris[i]);
               repeat ($urandom_range(2)) @(negedge clk);
            end
         end
         begin
            for (int i = 0; i < NUM_RANDOM; i++) begin
               receive_plane(model_plane(tris[i]), 30);
            end
         end
      join
   endtask

   initial begin
      void'($urandom(32'hff14));
      clk       = 1'b0;
      rst       = 1'b1;
      in_valid  = 1'b0;
      in_tri    = '0;
      out_ready = 1'b0;
      repeat (8) @(negedge clk);
      rst = 1'b0;
      @(negedge clk);
      compare_flag("in_ready", 1'b1, in_ready);
      compare_flag("out_valid", 1'b0, out_valid);
      test_linear_ccw();
      test_clockwise();
      test_collinear();
      test_backpressure();
      test_random();
      $display("Simulation passed");
      $finish;
   end

endmodule

// File: logic/tri_setup.sv
`timescale 1ns/1ps

module tri_setup (
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      in_valid,
   output logic                      in_ready,
   input  tri_setup_pkg::triangle_t  in_tri,
   output logic                      out_valid,
   input  logic                      out_ready,
   output tri_setup_pkg::plane_t     out_plane
);
   import tri_setup_pkg::*;

   logic   area_ready, num_ready;
   logic   area_valid, num_valid;
   logic   join_ready;
   area_t  area;
   numer_t numer;

   // Fork: each unit takes the triangle only when the other can too.
   assign in_ready = area_ready && num_ready;

   area_unit u_area (
      .clk      (clk),
      .rst      (rst),
      .in_valid (in_valid && num_ready),
      .in_ready (area_ready),
      .in_tri   (in_tri),
      .out_valid(area_valid),
      .out_ready(join_ready),
      .area     (area)
   );

   numerator_unit u_numer (
      .clk      (clk),
      .rst      (rst),
      .in_valid (in_valid && area_ready),
      .in_ready (num_ready),
      .in_tri   (in_tri),
      .out_valid(num_valid),
      .out_ready(join_ready),
      .numer    (numer)
   );

   plane_divider u_div (
      .clk       (clk),
      .rst       (rst),
      .area_valid(area_valid),
      .num_valid (num_valid),
      .join_ready(join_ready),
      .area      (area),
      .numer     (numer),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .out_plane (out_plane)
   );

endmodule

// File: logic/plane_divider.sv
`timescale 1ns/1ps
`include "tri_setup_params.svh"

module plane_divider (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   area_valid,
   input  logic                   num_valid,
   output logic                   join_ready,
   input  tri_setup_pkg::area_t   area,
   input  tri_setup_pkg::numer_t  numer,
   output logic                   out_valid,
   input  logic                   out_ready,
   output tri_setup_pkg::plane_t  out_plane
);
   import tri_setup_pkg::*;

   localparam int CNT_W = $clog2(`DIV_STEPS);

   typedef enum logic [1:0] {S_IDLE, S_DIV, S_FIN, S_HOLD} state_t;

   state_t             state;
   logic [CNT_W-1:0]   step_cnt;
   logic               join_fire;
   logic               det_zero;
   logic [`COEF_W-1:0] divisor;
   logic               degen;
   logic [2:0]         neg;
   logic [2:0]         qbit;
   logic [`COEF_W-1:0] num_word [3];
   logic [`COEF_W-1:0] dvd [3];
   logic [`COEF_W-1:0] rem [3];
   logic [`COEF_W-1:0] quo [3];
   logic [`COEF_W:0]   trial [3];
   logic [`COEF_W:0]   diff [3];
   coef_t              res [3];

   function automatic logic [`COEF_W-1:0] abs_val(input logic [`COEF_W-1:0] v);
      return v[`COEF_W-1] ? (~v + 1'b1) : v;
   endfunction

   assign num_word[0] = numer.num_cx;
   assign num_word[1] = numer.num_cy;
   assign num_word[2] = numer.num_cs;

   // Both front stages must be valid, so they always leave together.
   assign join_ready = (state == S_IDLE) && area_valid && num_valid;
   assign join_fire  = join_ready;
   assign det_zero   = (area.det == '0);
   assign out_valid  = (state == S_HOLD);

   // One restoring step per lane against the shared divisor.
   always_comb begin
      for (int i = 0; i < 3; i++) begin
         trial[i] = {rem[i], dvd[i][`COEF_W-1]};
         diff[i]  = trial[i] - {1'b0, divisor};
         qbit[i]  = !diff[i][`COEF_W];
         res[i]   = neg[i] ? -quo[i] : quo[i];
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state    <= S_IDLE;
         step_cnt <= '0;
      end else begin
         case (state)
            S_IDLE: begin
               if (join_fire) begin
                  state    <= det_zero ? S_FIN : S_DIV;
                  step_cnt <= '0;
               end
            end
            S_DIV: begin
               step_cnt <= step_cnt + 1'b1;
               if (step_cnt == CNT_W'(`DIV_STEPS - 1)) begin
                  state <= S_FIN;
               end
            end
            S_FIN: state <= S_HOLD;
            S_HOLD: begin
               if (out_ready) begin
                  state <= S_IDLE;
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   // Datapath. Zeros shift into the dividend for the fraction steps.
   always_ff @(posedge clk) begin
      if (join_fire) begin
         divisor <= abs_val(area.det);
         degen   <= det_zero;
         for (int i = 0; i < 3; i++) begin
            dvd[i] <= abs_val(num_word[i]);
            rem[i] <= '0;
            quo[i] <= '0;
            neg[i] <= num_word[i][`COEF_W-1] ^ area.det[`COEF_W-1];
         end
      end else if (state == S_DIV) begin
         for (int i = 0; i < 3; i++) begin
            dvd[i] <= dvd[i] << 1;
            rem[i] <= qbit[i] ? diff[i][`COEF_W-1:0] : trial[i][`COEF_W-1:0];
            // Older bits fall off the top, only 111..48 survive.
            quo[i] <= {quo[i][`COEF_W-2:0], qbit[i]};
         end
      end
   end

   always_ff @(posedge clk) begin
      if (state == S_FIN) begin
         out_plane.cx         <= degen ? '0 : res[0];
         out_plane.cy         <= degen ? '0 : res[1];
         out_plane.cs         <= degen ? '0 : res[2];
         out_plane.degenerate <= degen;
      end
   end

   a_divisor_nonzero: assert property (@(posedge clk) disable iff (rst)
      state == S_DIV |-> divisor != '0);

   a_plane_stable: assert property (@(posedge clk) disable iff (rst)
      out_valid && !out_ready |=> out_valid && $stable(out_plane));

endmodule

// File: logic/numerator_unit.sv
`timescale 1ns/1ps
`include "tri_setup_params.svh"

module numerator_unit (
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      in_valid,
   output logic                      in_ready,
   input  tri_setup_pkg::triangle_t  in_tri,
   output logic                      out_valid,
   input  logic                      out_ready,
   output tri_setup_pkg::numer_t     numer
);
   import tri_setup_pkg::*;

   logic [`COEF_W-1:0] x0, y0, x1, y1, x2, y2;
   logic [`COEF_W-1:0] s0, s1, s2;
   logic [`COEF_W-1:0] cross0, cross1, cross2;
   numer_t             numer_d;

   assign x0 = `COEF_W'(in_tri.x0);
   assign y0 = `COEF_W'(in_tri.y0);
   assign x1 = `COEF_W'(in_tri.x1);
   assign y1 = `COEF_W'(in_tri.y1);
   assign x2 = `COEF_W'(in_tri.x2);
   assign y2 = `COEF_W'(in_tri.y2);
   assign s0 = `COEF_W'(in_tri.s0);
   assign s1 = `COEF_W'(in_tri.s1);
   assign s2 = `COEF_W'(in_tri.s2);

   // Cross products of the opposite vertex pairs.
   assign cross0 = x1 * y2 - x2 * y1;
   assign cross1 = x2 * y0 - x0 * y2;
   assign cross2 = x0 * y1 - x1 * y0;

   assign numer_d.num_cx = s0 * (y1 - y2) + s1 * (y2 - y0) + s2 * (y0 - y1);
   assign numer_d.num_cy = s0 * (x2 - x1) + s1 * (x0 - x2) + s2 * (x1 - x0);
   assign numer_d.num_cs = s0 * cross0 + s1 * cross1 + s2 * cross2;

   pipe_stage #(
      .payload_t(numer_t)
   ) u_stage (
      .clk      (clk),
      .rst      (rst),
      .in_valid (in_valid),
      .in_ready (in_ready),
      .in_data  (numer_d),
      .out_valid(out_valid),
      .out_ready(out_ready),
      .out_data (numer)
   );

endmodule

// File: logic/area_unit.sv
`timescale 1ns/1ps
`include "tri_setup_params.svh"

module area_unit (
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      in_valid,
   output logic                      in_ready,
   input  tri_setup_pkg::triangle_t  in_tri,
   output logic                      out_valid,
   input  logic                      out_ready,
   output tri_setup_pkg::area_t      area
);
   import tri_setup_pkg::*;

   logic [`COEF_W-1:0] x0, y0, x1, y1, x2, y2;
   area_t              area_d;

   // Zero-extended coordinates.
   assign x0 = `COEF_W'(in_tri.x0);
   assign y0 = `COEF_W'(in_tri.y0);
   assign x1 = `COEF_W'(in_tri.x1);
   assign y1 = `COEF_W'(in_tri.y1);
   assign x2 = `COEF_W'(in_tri.x2);
   assign y2 = `COEF_W'(in_tri.y2);

   // Wraps to a two's complement result, negative for clockwise order.
   assign area_d.det = x0 * (y1 - y2) + x1 * (y2 - y0) + x2 * (y0 - y1);

   pipe_stage #(
      .payload_t(area_t)
   ) u_stage (
      .clk      (clk),
      .rst      (rst),
      .in_valid (in_valid),
      .in_ready (in_ready),
      .in_data  (area_d),
      .out_valid(out_valid),
      .out_ready(out_ready),
      .out_data (area)
   );

endmodule

// File: logic/pipe_stage.sv
`timescale 1ns/1ps

module pipe_stage #(
   parameter type payload_t = logic
) (
   input  logic     clk,
   input  logic     rst,
   input  logic     in_valid,
   output logic     in_ready,
   input  payload_t in_data,
   output logic     out_valid,
   input  logic     out_ready,
   output payload_t out_data
);

   // Room when empty or when the held item leaves this cycle.
   assign in_ready = !out_valid || out_ready;

   always_ff @(posedge clk) begin
      if (rst) begin
         out_valid <= 1'b0;
      end else if (in_ready) begin
         out_valid <= in_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (in_valid && in_ready) begin
         out_data <= in_data;
      end
   end

   a_stall_stable: assert property (@(posedge clk) disable iff (rst)
      out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

// File: logic/tri_setup_pkg.sv
`include "tri_setup_params.svh"

package tri_setup_pkg;

   // Signed fixed-point word, also used for the raw numerators.
   typedef logic signed [`COEF_W-1:0] coef_t;

   // One triangle with a single attribute per vertex.
   typedef struct packed {
      logic [`COORD_W-1:0] x0;
      logic [`COORD_W-1:0] y0;
      logic [`COORD_W-1:0] x1;
      logic [`COORD_W-1:0] y1;
      logic [`COORD_W-1:0] x2;
      logic [`COORD_W-1:0] y2;
      logic [`ATTR_W-1:0]  s0;
      logic [`ATTR_W-1:0]  s1;
      logic [`ATTR_W-1:0]  s2;
   } triangle_t;

   // Twice the signed triangle area.
   typedef struct packed {
      coef_t det;
   } area_t;

   // Coefficient numerators before the divide.
   typedef struct packed {
      coef_t num_cx;
      coef_t num_cy;
      coef_t num_cs;
   } numer_t;

   // Final attribute plane.
   typedef struct packed {
      coef_t cx;
      coef_t cy;
      coef_t cs;
      logic  degenerate;
   } plane_t;

endpackage

// File: include/tri_setup_params.svh
`ifndef TRI_SETUP_PARAMS_SVH
`define TRI_SETUP_PARAMS_SVH

// Vertex coordinate width.
`define COORD_W 12

// Per-vertex attribute width.
`define ATTR_W 12

// Internal arithmetic and coefficient width.
`define COEF_W 64

// Fraction bits of each plane coefficient.
`define FRAC_BITS 16

// One quotient bit per step, dividend bits 127 down to 48.
`define DIV_STEPS (`COEF_W + `FRAC_BITS)

`endif
